// File: compile.f
source/zynq_shell_pkg.sv
source/csr_decode.sv
source/dram_access_monitor.sv
source/csr_readback.sv
source/zynq_shell_top.sv
bench/tb_zynq_shell.sv

// File: run_sim.sh
#!/bin/sh
# build and run the shell testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module tb_zynq_shell -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vtb_zynq_shell > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^RESULT: PASS$" "$log"; then
   exit 0
fi

echo "pass message not found in $log"
exit 1

// File: bench/tb_zynq_shell.sv
`timescale 1ns/1ns
`default_nettype none

module tb_zynq_shell;

   localparam int read_timeout_lp = 16;
   localparam logic [31:0] lfsr_taps_lp = 32'h8020_0003;

   logic         aclk_i;
   logic         rst_n_i;
   logic         host_wr_v_i;
   logic         host_rd_v_i;
   logic [9:0]   host_addr_i;
   logic [31:0]  host_wdata_i;
   logic [31:0]  host_rdata_o;
   logic         host_rdata_v_o;
   logic [31:0]  bp_awaddr_i;
   logic         bp_awvalid_i;
   logic         bp_awready_o;
   logic [31:0]  m_awaddr_o;
   logic         m_awvalid_o;
   logic         m_awready_i;
   logic [31:0]  bp_araddr_i;
   logic         bp_arvalid_i;
   logic         bp_arready_o;
   logic [31:0]  m_araddr_o;
   logic         m_arvalid_o;
   logic         m_arready_i;

   // reference model of the shell state
   logic         sysrst_model;
   logic         init_model;
   logic         overrun_model;
   logic [31:0]  base_model;
   logic [31:0]  wr_model;
   logic [31:0]  rd_model;
   logic [127:0] profile_model;

   logic [31:0]  lfsr_state;
   int           errors;
   int           checks;
   int           tests;

   zynq_shell_top #(
      .dram_addr_width (32),
      .count_width     (32)
   ) dut0 (
      .aclk_i         (aclk_i),
      .rst_n_i        (rst_n_i),
      .host_wr_v_i    (host_wr_v_i),
      .host_rd_v_i    (host_rd_v_i),
      .host_addr_i    (host_addr_i),
      .host_wdata_i   (host_wdata_i),
      .host_rdata_o   (host_rdata_o),
      .host_rdata_v_o (host_rdata_v_o),
      .bp_awaddr_i    (bp_awaddr_i),
      .bp_awvalid_i   (bp_awvalid_i),
      .bp_awready_o   (bp_awready_o),
      .m_awaddr_o     (m_awaddr_o),
      .m_awvalid_o    (m_awvalid_o),
      .m_awready_i    (m_awready_i),
      .bp_araddr_i    (bp_araddr_i),
      .bp_arvalid_i   (bp_arvalid_i),
      .bp_arready_o   (bp_arready_o),
      .m_araddr_o     (m_araddr_o),
      .m_arvalid_o    (m_arvalid_o),
      .m_arready_i    (m_arready_i)
   );

   initial
   begin
      aclk_i = 1'b0;
      forever #4 aclk_i = ~aclk_i;
   end

   ////////////////////
   // helpers

   function automatic logic [31:0] galois_step(input logic [31:0] s);
      begin
         if (s[0])
         begin
            return (s >> 1) ^ lfsr_taps_lp;
         end
         return s >> 1;
      end
   endfunction

   // one lfsr step per bit handed out
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      begin
         v = '0;
         for (int i = 0; i < n; i++)
         begin
            lfsr_state = galois_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
         end
         return v;
      end
   endfunction

   // 8 MB regions selected by address bits 29 down to 23
   function automatic logic [6:0] region_of(input logic [31:0] a);
      begin
         return a[29:23];
      end
   endfunction

   function automatic logic [31:0] expected_reg(input int idx);
      logic [31:0] v;
      begin
         case (idx)
            0: v = {29'b0, sysrst_model, overrun_model, init_model};
            1, 2, 3, 4: v = profile_model[(idx-1)*32 +: 32];
            5: v = wr_model;
            6: v = rd_model;
            default: v = base_model;
         endcase
         return v;
      end
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      begin
         checks++;
         if (got !== exp)
         begin
            errors++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         end
      end
   endtask

   task automatic clear_model();
      begin
         profile_model = '0;
         overrun_model = 1'b0;
         wr_model      = '0;
         rd_model      = '0;
      end
   endtask

   task automatic host_write(input int idx, input logic [31:0] data);
      begin
         @(negedge aclk_i);
         host_wr_v_i  = 1'b1;
         host_addr_i  = 10'(idx * 4);
         host_wdata_i = data;
         @(negedge aclk_i);
         host_wr_v_i  = 1'b0;
         case (idx)
            0:
            begin
               sysrst_model = data[0];
               if (!data[0])
               begin
                  clear_model();
               end
            end
            1: init_model = data[0];
            2: base_model = data;
            default:
            begin
               // ignored by the shell
            end
         endcase
      end
   endtask

   // response must come exactly one cycle after the strobe
   task automatic host_read(input int idx, output logic [31:0] data);
      int   waited;
      logic got;
      begin
         @(negedge aclk_i);
         // idle after reset and after the previous single cycle pulse
         check_value("read data valid before strobe", 32'(host_rdata_v_o), 32'd0);
         host_rd_v_i = 1'b1;
         host_addr_i = 10'(idx * 4);
         waited = 0;
         got    = 1'b0;
         while (!got && waited < read_timeout_lp)
         begin
            @(negedge aclk_i);
            waited++;
            host_rd_v_i = 1'b0;
            if (host_rdata_v_o)
            begin
               got = 1'b1;
            end
         end
         if (!got)
         begin
            $display("read of index %0d timed out after %0d cycles", idx, waited);
            $display("RESULT: FAIL");
            $finish;
         end
         else
         begin
            checks++;
            if (waited != 1)
            begin
               errors++;
               $display("mismatch at %0t ns: read data came %0d cycles after the strobe",
                        $time, waited);
            end
            data = host_rdata_o;
         end
      end
   endtask

   task automatic check_all_regs(input string tag);
      logic [31:0] d;
      begin
         for (int i = 0; i < 8; i++)
         begin
            host_read(i, d);
            check_value($sformatf("%s index %0d", tag, i), d, expected_reg(i));
         end
      end
   endtask

   // one cycle of address traffic sampled at the next rising edge
   task automatic drive_channels(input logic [31:0] aw_a, input logic aw_v, input logic aw_r,
                                 input logic [31:0] ar_a, input logic ar_v, input logic ar_r);
      logic [31:0] aw_off;
      logic [31:0] ar_off;
      begin
         @(negedge aclk_i);
         bp_awaddr_i  = aw_a;
         bp_awvalid_i = aw_v;
         m_awready_i  = aw_r;
         bp_araddr_i  = ar_a;
         bp_arvalid_i = ar_v;
         m_arready_i  = ar_r;
         #1;
         aw_off = aw_a ^ zynq_shell_pkg::proc_dram_base;
         ar_off = ar_a ^ zynq_shell_pkg::proc_dram_base;
         check_value("aw address", m_awaddr_o, aw_off + base_model);
         check_value("ar address", m_araddr_o, ar_off + base_model);
         check_value("aw valid", 32'(m_awvalid_o), 32'(aw_v));
         check_value("ar valid", 32'(m_arvalid_o), 32'(ar_v));
         check_value("aw ready", 32'(bp_awready_o), 32'(aw_r));
         check_value("ar ready", 32'(bp_arready_o), 32'(ar_r));
         if (sysrst_model)
         begin
            if (aw_v)
            begin
               profile_model[region_of(aw_a)] = 1'b1;
               if ({32'b0, aw_off} >= zynq_shell_pkg::dram_limit_bytes)
               begin
                  overrun_model = 1'b1;
               end
            end
            if (ar_v)
            begin
               profile_model[region_of(ar_a)] = 1'b1;
               if ({32'b0, ar_off} >= zynq_shell_pkg::dram_limit_bytes)
               begin
                  overrun_model = 1'b1;
               end
            end
            if (aw_v && aw_r)
            begin
               wr_model = wr_model + 32'd1;
            end
            if (ar_v && ar_r)
            begin
               rd_model = rd_model + 32'd1;
            end
         end
      end
   endtask

   task automatic finish_test(input string name, input int start_errors);
      begin
         tests++;
         $display("%s: done, %0d errors", name, errors - start_errors);
      end
   endtask

   ////////////////////
   // tests

   task automatic reset_defaults();
      int start;
      begin
         start = errors;
         check_all_regs("reset");
         // base is zero so only the xor shows
         for (int i = 0; i < 4; i++)
         begin
            drive_channels(rand_bits(32), 1'b1, 1'b1, rand_bits(32), 1'b1, 1'b0);
         end
         drive_channels('0, 1'b0, 1'b0, '0, 1'b0, 1'b0);
         check_all_regs("traffic under system reset");
         finish_test("reset_defaults", start);
      end
   endtask

   task automatic register_access();
      int          start;
      logic [31:0] base;
      logic [31:0] d;
      begin
         start = errors;
         base  = rand_bits(32);
         host_write(2, base);
         host_write(1, 32'd1);
         host_write(0, 32'd1);
         host_read(7, d);
         check_value("dram base", d, base);
         host_read(0, d);
         check_value("status", d, 32'h0000_0005);
         host_write(3, 32'hffff_ffff);
         host_write(6, 32'h1234_5678);
         check_all_regs("undefined write");
         finish_test("register_access", start);
      end
   endtask

   task automatic remap_sweep();
      int          start;
      logic [31:0] hs;
      begin
         start = errors;
         for (int i = 0; i < 20; i++)
         begin
            host_write(2, rand_bits(32));
            hs = rand_bits(4);
            drive_channels(rand_bits(32), hs[0], hs[1], rand_bits(32), hs[2], hs[3]);
            drive_channels('0, 1'b0, 1'b0, '0, 1'b0, 1'b0);
         end
         check_all_regs("remap sweep");
         finish_test("remap_sweep", start);
      end
   endtask

   task automatic profile_and_counters();
      int          start;
      logic [31:0] hs;
      begin
         start = errors;
         host_write(0, 32'd0);
         host_write(0, 32'd1);
         // a few fixed regions first with ready low and high
         drive_channels(32'h8000_0000, 1'b1, 1'b0, 32'h8080_0000, 1'b1, 1'b1);
         drive_channels(32'h8f80_0010, 1'b1, 1'b1, 32'h8400_0000, 1'b0, 1'b1);
         drive_channels(32'h3f80_0000, 1'b1, 1'b1, 32'h2000_0000, 1'b1, 1'b0);
         for (int i = 0; i < 20; i++)
         begin
            hs = rand_bits(4);
            drive_channels(rand_bits(32), hs[0], hs[1], rand_bits(32), hs[2], hs[3]);
         end
         drive_channels('0, 1'b0, 1'b0, '0, 1'b0, 1'b0);
         check_all_regs("profiler and counters");
         finish_test("profile_and_counters", start);
      end
   endtask

   task automatic overrun_and_clear();
      int          start;
      logic [31:0] d;
      begin
         start = errors;
         host_write(0, 32'd0);
         host_write(0, 32'd1);
         // last words below the limit
         drive_channels(32'h8123_4560, 1'b1, 1'b1, 32'h8fff_fffc, 1'b1, 1'b1);
         drive_channels('0, 1'b0, 1'b0, '0, 1'b0, 1'b0);
         host_read(0, d);
         check_value("overrun below limit", 32'(d[1]), 32'd0);
         // first byte at the limit
         drive_channels(32'h9000_0000, 1'b1, 1'b0, '0, 1'b0, 1'b0);
         drive_channels('0, 1'b0, 1'b0, '0, 1'b0, 1'b0);
         host_read(0, d);
         check_value("overrun at limit", 32'(d[1]), 32'd1);
         check_all_regs("overrun");
         host_write(0, 32'd0);
         host_write(0, 32'd1);
         check_all_regs("system reset clear");
         finish_test("overrun_and_clear", start);
      end
   endtask

   ////////////////////
   // sequence

   initial
   begin
      rst_n_i      = 1'b0;
      host_wr_v_i  = 1'b0;
      host_rd_v_i  = 1'b0;
      host_addr_i  = '0;
      host_wdata_i = '0;
      bp_awaddr_i  = '0;
      bp_awvalid_i = 1'b0;
      m_awready_i  = 1'b0;
      bp_araddr_i  = '0;
      bp_arvalid_i = 1'b0;
      m_arready_i  = 1'b0;
      lfsr_state   = 32'hcf20;
      errors       = 0;
      checks       = 0;
      tests        = 0;
      sysrst_model = 1'b0;
      init_model   = 1'b0;
      base_model   = '0;
      clear_model();

      repeat (2) @(negedge aclk_i);
      rst_n_i = 1'b1;

      reset_defaults();
      register_access();
      remap_sweep();
      profile_and_counters();
      overrun_and_clear();

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
      begin
         $display("RESULT: PASS");
      end
      else
      begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: source/zynq_shell_top.sv
`timescale 1ns/1ns
`default_nettype none

module zynq_shell_top
#(
   parameter int dram_addr_width = 32,
   parameter int count_width     = 32
)
(
   input  logic                                      aclk_i,
   input  logic                                      rst_n_i,

   // host register port
   input  logic                                      host_wr_v_i,
   input  logic                                      host_rd_v_i,
   input  logic [zynq_shell_pkg::csr_addr_width-1:0] host_addr_i,
   input  logic [zynq_shell_pkg::csr_data_width-1:0] host_wdata_i,
   output logic [zynq_shell_pkg::csr_data_width-1:0] host_rdata_o,
   output logic                                      host_rdata_v_o,

   // dram write address
   input  logic [dram_addr_width-1:0]                bp_awaddr_i,
   input  logic                                      bp_awvalid_i,
   output logic                                      bp_awready_o,
   output logic [dram_addr_width-1:0]                m_awaddr_o,
   output logic                                      m_awvalid_o,
   input  logic                                      m_awready_i,

   // dram read address
   input  logic [dram_addr_width-1:0]                bp_araddr_i,
   input  logic                                      bp_arvalid_i,
   output logic                                      bp_arready_o,
   output logic [dram_addr_width-1:0]                m_araddr_o,
   output logic                                      m_arvalid_o,
   input  logic                                      m_arready_i
);

   logic                                       sys_resetn;
   logic                                       dram_init;
   logic [dram_addr_width-1:0]                 dram_base;
   logic [zynq_shell_pkg::profile_regions-1:0] profile_bits;
   logic                                       overrun;
   logic [count_width-1:0]                     wr_count;
   logic [count_width-1:0]                     rd_count;

   ////////////////////
   // host writes

   csr_decode #(
      .dram_addr_width (dram_addr_width)
   ) decode0 (
      .aclk_i       (aclk_i),
      .rst_n_i      (rst_n_i),
      .host_wr_v_i  (host_wr_v_i),
      .host_rd_v_i  (host_rd_v_i),
      .host_addr_i  (host_addr_i),
      .host_wdata_i (host_wdata_i),
      .sys_resetn_o (sys_resetn),
      .dram_init_o  (dram_init),
      .dram_base_o  (dram_base)
   );

   ////////////////////
   // address channels

   dram_access_monitor #(
      .dram_addr_width (dram_addr_width),
      .count_width     (count_width)
   ) monitor0 (
      .aclk_i         (aclk_i),
      .rst_n_i        (rst_n_i),
      .sys_resetn_i   (sys_resetn),
      .dram_base_i    (dram_base),
      .bp_awaddr_i    (bp_awaddr_i),
      .bp_awvalid_i   (bp_awvalid_i),
      .bp_awready_o   (bp_awready_o),
      .m_awaddr_o     (m_awaddr_o),
      .m_awvalid_o    (m_awvalid_o),
      .m_awready_i    (m_awready_i),
      .bp_araddr_i    (bp_araddr_i),
      .bp_arvalid_i   (bp_arvalid_i),
      .bp_arready_o   (bp_arready_o),
      .m_araddr_o     (m_araddr_o),
      .m_arvalid_o    (m_arvalid_o),
      .m_arready_i    (m_arready_i),
      .profile_bits_o (profile_bits),
      .overrun_o      (overrun),
      .wr_count_o     (wr_count),
      .rd_count_o     (rd_count)
   );

   ////////////////////
   // host reads

   csr_readback #(
      .count_width (count_width)
   ) readback0 (
      .aclk_i         (aclk_i),
      .rst_n_i        (rst_n_i),
      .host_rd_v_i    (host_rd_v_i),
      .host_addr_i    (host_addr_i),
      .dram_init_i    (dram_init),
      .sys_resetn_i   (sys_resetn),
      .dram_base_i    (dram_base),
      .profile_bits_i (profile_bits),
      .overrun_i      (overrun),
      .wr_count_i     (wr_count),
      .rd_count_i     (rd_count),
      .host_rdata_o   (host_rdata_o),
      .host_rdata_v_o (host_rdata_v_o)
   );

endmodule

`default_nettype wire

// File: source/csr_readback.sv
`timescale 1ns/1ns
`default_nettype none

module csr_readback
#(
   parameter int count_width = 32
)
(
   input  logic                                       aclk_i,
   input  logic                                       rst_n_i,

   input  logic                                       host_rd_v_i,
   input  logic [zynq_shell_pkg::csr_addr_width-1:0]  host_addr_i,

   input  logic                                       dram_init_i,
   input  logic                                       sys_resetn_i,
   input  logic [zynq_shell_pkg::csr_data_width-1:0]  dram_base_i,
   input  logic [zynq_shell_pkg::profile_regions-1:0] profile_bits_i,
   input  logic                                       overrun_i,
   input  logic [count_width-1:0]                     wr_count_i,
   input  logic [count_width-1:0]                     rd_count_i,

   output logic [zynq_shell_pkg::csr_data_width-1:0]  host_rdata_o,
   output logic                                       host_rdata_v_o
);

   localparam int dw_lp = zynq_shell_pkg::csr_data_width;

   logic [zynq_shell_pkg::csr_index_width-1:0] rd_index;
   logic [dw_lp-1:0]                           status_word;
   logic [dw_lp-1:0]                           rd_sel;
   logic [dw_lp-1:0]                           rdata_r;
   logic                                       rdata_v_r;

   assign rd_index = host_addr_i[zynq_shell_pkg::csr_index_lsb +: zynq_shell_pkg::csr_index_width];

   always_comb
   begin
      status_word = '0;
      status_word[zynq_shell_pkg::status_dram_init_bit]  = dram_init_i;
      status_word[zynq_shell_pkg::status_overrun_bit]    = overrun_i;
      status_word[zynq_shell_pkg::status_sys_resetn_bit] = sys_resetn_i;
   end

   ////////////////////
   // read mux

   // all eight indices are defined
   always_comb
   begin
      case (rd_index)
         zynq_shell_pkg::csr_r_status:   rd_sel = status_word;
         zynq_shell_pkg::csr_r_profile0: rd_sel = profile_bits_i[0*dw_lp +: dw_lp];
         zynq_shell_pkg::csr_r_profile1: rd_sel = profile_bits_i[1*dw_lp +: dw_lp];
         zynq_shell_pkg::csr_r_profile2: rd_sel = profile_bits_i[2*dw_lp +: dw_lp];
         zynq_shell_pkg::csr_r_profile3: rd_sel = profile_bits_i[3*dw_lp +: dw_lp];
         zynq_shell_pkg::csr_r_wr_count: rd_sel = dw_lp'(wr_count_i);
         zynq_shell_pkg::csr_r_rd_count: rd_sel = dw_lp'(rd_count_i);
         default:                        rd_sel = dram_base_i;
      endcase
   end

   // one cycle response
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rdata_v_r <= 1'b0;
      end
      else
      begin
         rdata_v_r <= host_rd_v_i;
      end
   end

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rdata_r <= '0;
      end
      else if (host_rd_v_i)
      begin
         rdata_r <= rd_sel;
      end
   end

   assign host_rdata_o   = rdata_r;
   assign host_rdata_v_o = rdata_v_r;

   // no unsolicited responses
   rdata_v_after_rd_a : assert property
      (@(posedge aclk_i) disable iff (!rst_n_i) host_rdata_v_o |-> $past(host_rd_v_i))
      else $error("csr_readback: read data valid without a preceding read strobe");

endmodule

`default_nettype wire

// File: source/dram_access_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module dram_access_monitor
#(
   parameter int dram_addr_width = 32,
   parameter int count_width     = 32
)
(
   input  logic                                       aclk_i,
   input  logic                                       rst_n_i,

   input  logic                                       sys_resetn_i,
   input  logic [dram_addr_width-1:0]                 dram_base_i,

   // write address channel
   input  logic [dram_addr_width-1:0]                 bp_awaddr_i,
   input  logic                                       bp_awvalid_i,
   output logic                                       bp_awready_o,
   output logic [dram_addr_width-1:0]                 m_awaddr_o,
   output logic                                       m_awvalid_o,
   input  logic                                       m_awready_i,

   // read address channel
   input  logic [dram_addr_width-1:0]                 bp_araddr_i,
   input  logic                                       bp_arvalid_i,
   output logic                                       bp_arready_o,
   output logic [dram_addr_width-1:0]                 m_araddr_o,
   output logic                                       m_arvalid_o,
   input  logic                                       m_arready_i,

   output logic [zynq_shell_pkg::profile_regions-1:0] profile_bits_o,
   output logic                                       overrun_o,
   output logic [count_width-1:0]                     wr_count_o,
   output logic [count_width-1:0]                     rd_count_o
);

   localparam logic [dram_addr_width-1:0] proc_base_lp =
      dram_addr_width'(zynq_shell_pkg::proc_dram_base);
   localparam logic [dram_addr_width-1:0] limit_lp =
      dram_addr_width'(zynq_shell_pkg::dram_limit_bytes);
   localparam int region_width_lp =
      zynq_shell_pkg::profile_index_msb - zynq_shell_pkg::profile_index_lsb + 1;

   logic [dram_addr_width-1:0] aw_offset;
   logic [dram_addr_width-1:0] ar_offset;
   logic [region_width_lp-1:0] aw_region;
   logic [region_width_lp-1:0] ar_region;
   logic                       over_limit;

   logic [zynq_shell_pkg::profile_regions-1:0] profile_set;
   logic [zynq_shell_pkg::profile_regions-1:0] profile_r;
   logic                                       overrun_r;
   logic [count_width-1:0]                     wr_count_r;
   logic [count_width-1:0]                     rd_count_r;

   ////////////////////
   // address remap

   // strip the processor base, then move into the host allocation
   assign aw_offset  = bp_awaddr_i ^ proc_base_lp;
   assign ar_offset  = bp_araddr_i ^ proc_base_lp;
   assign m_awaddr_o = aw_offset + dram_base_i;
   assign m_araddr_o = ar_offset + dram_base_i;

   // handshakes go straight through, no added stall
   assign m_awvalid_o  = bp_awvalid_i;
   assign m_arvalid_o  = bp_arvalid_i;
   assign bp_awready_o = m_awready_i;
   assign bp_arready_o = m_arready_i;

   ////////////////////
   // profiler and range check

   assign aw_region = bp_awaddr_i[zynq_shell_pkg::profile_index_msb:zynq_shell_pkg::profile_index_lsb];
   assign ar_region = bp_araddr_i[zynq_shell_pkg::profile_index_msb:zynq_shell_pkg::profile_index_lsb];

   // a presented address marks its region, accepted or not
   always_comb
   begin
      profile_set = '0;
      if (bp_awvalid_i)
      begin
         profile_set[aw_region] = 1'b1;
      end
      if (bp_arvalid_i)
      begin
         profile_set[ar_region] = 1'b1;
      end
   end

   assign over_limit = (bp_awvalid_i && (aw_offset >= limit_lp))
                    || (bp_arvalid_i && (ar_offset >= limit_lp));

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         profile_r  <= '0;
         overrun_r  <= 1'b0;
         wr_count_r <= '0;
         rd_count_r <= '0;
      end
      else if (!sys_resetn_i)
      begin
         // held clear while the system is in reset
         profile_r  <= '0;
         overrun_r  <= 1'b0;
         wr_count_r <= '0;
         rd_count_r <= '0;
      end
      else
      begin
         profile_r <= profile_r | profile_set;
         if (over_limit)
         begin
            overrun_r <= 1'b1;
         end
         if (bp_awvalid_i && m_awready_i)
         begin
            wr_count_r <= wr_count_r + count_width'(1);
         end
         if (bp_arvalid_i && m_arready_i)
         begin
            rd_count_r <= rd_count_r + count_width'(1);
         end
      end
   end

   assign profile_bits_o = profile_r;
   assign overrun_o      = overrun_r;
   assign wr_count_o     = wr_count_r;
   assign rd_count_o     = rd_count_r;

   ////////////////////
   // checks

   profile_clear_a : assert property
      (@(posedge aclk_i) disable iff (!rst_n_i) !sys_resetn_i |=> (profile_r == '0))
      else $error("dram_access_monitor: profiler not clear under system reset");

   wr_count_hold_a : assert property
      (@(posedge aclk_i) disable iff (!rst_n_i)
       !(bp_awvalid_i && m_awready_i) |=> ($stable(wr_count_r) || (wr_count_r == '0)))
      else $error("dram_access_monitor: write count moved without a handshake");

   rd_count_hold_a : assert property
      (@(posedge aclk_i) disable iff (!rst_n_i)
       !(bp_arvalid_i && m_arready_i) |=> ($stable(rd_count_r) || (rd_count_r == '0)))
      else $error("dram_access_monitor: read count moved without a handshake");

endmodule

`default_nettype wire

// File: source/csr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module csr_decode
#(
   parameter int dram_addr_width = 32
)
(
   input  logic                                      aclk_i,
   input  logic                                      rst_n_i,

   input  logic                                      host_wr_v_i,
   input  logic                                      host_rd_v_i,
   input  logic [zynq_shell_pkg::csr_addr_width-1:0] host_addr_i,
   input  logic [zynq_shell_pkg::csr_data_width-1:0] host_wdata_i,

   output logic                                      sys_resetn_o,
   output logic                                      dram_init_o,
   output logic [dram_addr_width-1:0]                dram_base_o
);

   logic [zynq_shell_pkg::csr_index_width-1:0] wr_index;

   logic                       sys_resetn_r;
   logic                       dram_init_r;
   logic [dram_addr_width-1:0] dram_base_r;

   // word index out of the byte address
   assign wr_index = host_addr_i[zynq_shell_pkg::csr_index_lsb +: zynq_shell_pkg::csr_index_width];

   ////////////////////
   // config registers

   // system reset is active low, so the core stays held until the host writes 1
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         sys_resetn_r <= 1'b0;
         dram_init_r  <= 1'b0;
         dram_base_r  <= '0;
      end
      else if (host_wr_v_i)
      begin
         case (wr_index)
            zynq_shell_pkg::csr_w_sys_resetn:
            begin
               sys_resetn_r <= host_wdata_i[0];
            end
            zynq_shell_pkg::csr_w_dram_init:
            begin
               dram_init_r <= host_wdata_i[0];
            end
            zynq_shell_pkg::csr_w_dram_base:
            begin
               dram_base_r <= dram_addr_width'(host_wdata_i);
            end
            default:
            begin
               // undefined indices are dropped
            end
         endcase
      end
   end

   assign sys_resetn_o = sys_resetn_r;
   assign dram_init_o  = dram_init_r;
   assign dram_base_o  = dram_base_r;

   ////////////////////
   // checks

   // the host port serializes its accesses, readback relies on it
   host_wr_rd_exclusive_a : assert property
      (@(posedge aclk_i) disable iff (!rst_n_i) !(host_wr_v_i && host_rd_v_i))
      else $error("csr_decode: read and write strobes in the same cycle");

endmodule

`default_nettype wire

// File: source/zynq_shell_pkg.sv
`default_nettype none

package zynq_shell_pkg;

   ////////////////////
   // host register port

   localparam int csr_data_width  = 32;
   localparam int csr_addr_width  = 10;
   localparam int csr_index_width = 3;
   // register index sits above the byte offset
   localparam int csr_index_lsb   = 2;

   // writable registers
   localparam logic [csr_index_width-1:0] csr_w_sys_resetn = 3'd0;
   localparam logic [csr_index_width-1:0] csr_w_dram_init  = 3'd1;
   localparam logic [csr_index_width-1:0] csr_w_dram_base  = 3'd2;

   // readable registers
   localparam logic [csr_index_width-1:0] csr_r_status    = 3'd0;
   localparam logic [csr_index_width-1:0] csr_r_profile0  = 3'd1;
   localparam logic [csr_index_width-1:0] csr_r_profile1  = 3'd2;
   localparam logic [csr_index_width-1:0] csr_r_profile2  = 3'd3;
   localparam logic [csr_index_width-1:0] csr_r_profile3  = 3'd4;
   localparam logic [csr_index_width-1:0] csr_r_wr_count  = 3'd5;
   localparam logic [csr_index_width-1:0] csr_r_rd_count  = 3'd6;
   localparam logic [csr_index_width-1:0] csr_r_dram_base = 3'd7;

   // status word layout
   localparam int status_dram_init_bit  = 0;
   localparam int status_overrun_bit    = 1;
   localparam int status_sys_resetn_bit = 2;

   ////////////////////
   // dram window

   // processor sees dram at this base, host memory starts at zero
   localparam logic [31:0] proc_dram_base = 32'h8000_0000;

   // 256 MB handed out by the host
   localparam logic [63:0] dram_limit_bytes = 64'h0000_0000_1000_0000;

   // one profiler bit per 8 MB region
   localparam int profile_regions   = 128;
   localparam int profile_index_msb = 29;
   localparam int profile_index_lsb = 23;

endpackage

`default_nettype wire
